/* compile.f */
design/fetch_pkg.sv
design/mem_load_if.sv
design/fetch_csr.sv
design/pc_unit.sv
design/sync_store.sv
design/fetch_top.sv
sim/fetch_chk.sv
sim/fetch_tb.sv

/* Bender.yml */
package:
  name: fetch_stage

dependencies: {}

sources:
  # rtl, in compile order
  - files:
      - design/fetch_pkg.sv
      - design/mem_load_if.sv
      - design/fetch_csr.sv
      - design/pc_unit.sv
      - design/sync_store.sv
      - design/fetch_top.sv

  # testbench and bound checker
  - target: simulation
    files:
      - sim/fetch_chk.sv
      - sim/fetch_tb.sv

/* sim/fetch_tb.sv */
`timescale 1ns/1ns

module fetch_tb;
    import fetch_pkg::*;

    localparam int mem_depth_bits = 8;
    localparam int depth          = 2 ** mem_depth_bits;
    localparam int max_cycles     = 2000;       // well past the full test sequence

    logic                      clk;
    logic                      rst_n;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    word_t                     paddr;
    word_t                     pwdata;
    word_t                     prdata;
    logic                      pready;
    logic                      pslverr;
    logic                      hold;
    logic                      no_op;
    logic                      branch;
    word_t                     branch_offset;
    logic                      jump;
    word_t                     jump_target;
    logic [mem_depth_bits-1:0] dmem_addr;
    word_t                     pc;
    word_t                     instr_pc;
    instr_t                    instruction;
    logic                      if_no_op;
    word_t                     dmem_rdata;

    word_t imem_model [depth];                  // expected instruction store
    word_t dmem_model [depth];                  // expected data store
    int    seed         = 32'hfd8d;
    int    cycle_count  = 0;
    int    test_errors  = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;

    fetch_top #(.mem_depth_bits(mem_depth_bits)) fetch_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                 // 20 ns period
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("sim failed");
            $finish;
        end
    end

    // word index of a byte address inside one store
    function automatic int fetch_index(input word_t addr);
        return int'(addr[mem_depth_bits+1:2]);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;                                     // drive point after the edge
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            test_errors++;
        end
    endtask

    // one zero wait state apb transfer, starts and ends at the drive point
    task automatic apb_access(input word_t addr, input logic wr, input word_t wdata,
                              output word_t rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        next_cycle();
        penable = 1'b1;                         // access phase
        #8;
        rdata   = prdata;                       // mid cycle, settled
        err     = pslverr;
        check_word("apb pready", 32'd1, word_t'(pready));   // no wait states
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input string name, input word_t addr, input word_t wdata);
        word_t rdata;
        logic  err;
        apb_access(addr, 1'b1, wdata, rdata, err);
        check_word({name, " write pslverr"}, 32'd0, word_t'(err));
    endtask

    // load address then a burst of data writes, model follows the auto increment
    task automatic load_words(input string name, input word_t base, input int count);
        word_t w;
        int    idx;
        apb_write(name, csr_addr_off, base);
        for (int i = 0; i < count; i++) begin
            w   = $random(seed);
            idx = (int'(base[mem_depth_bits-1:0]) + i) % depth;
            if (base[mem_depth_bits]) begin
                dmem_model[idx] = w;
            end else begin
                imem_model[idx] = w;
            end
            apb_write(name, csr_data_off, w);
        end
    endtask

    task automatic restart_fetch(input string name, input word_t start);
        apb_write(name, csr_start_off, start);
        apb_write(name, csr_ctrl_off, 32'd0);   // leave load mode
        next_cycle();
        check_word({name, " restart pc"}, start, pc);
    endtask

    task automatic check_fetch_run(input string name, input word_t start, input int count);
        for (int i = 0; i < count; i++) begin
            next_cycle();
            check_word({name, " instr_pc"}, start + 4 * i, instr_pc);
            check_word({name, " instruction"}, imem_model[fetch_index(start + 4 * i)],
                       instruction);
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    initial begin
        word_t  rdata;
        logic   err;
        word_t  base_pc;
        word_t  offset;
        word_t  target;
        word_t  frozen_pc;
        instr_t held_instr;
        int     release_cycle;

        rst_n         = 1'b0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        hold          = 1'b0;
        no_op         = 1'b0;
        branch        = 1'b0;
        branch_offset = '0;
        jump          = 1'b0;
        jump_target   = '0;
        dmem_addr     = '0;
        for (int i = 0; i < depth; i++) begin
            imem_model[i] = '0;                 // stores power up cleared
            dmem_model[i] = '0;
        end
        repeat (8) @(posedge clk);
        #2;
        rst_n         = 1'b1;
        release_cycle = cycle_count;

        apb_write("registers", csr_start_off, 32'h0000_0040);
        apb_access(csr_start_off, 1'b0, 32'd0, rdata, err);
        check_word("registers start_pc", 32'h0000_0040, rdata);
        apb_write("registers", csr_ctrl_off, 32'd1 << ctrl_load_bit);
        frozen_pc = word_t'(4 * (cycle_count - release_cycle));   // one step per edge
        apb_access(csr_ctrl_off, 1'b0, 32'd0, rdata, err);
        check_word("registers ctrl", 32'd1 << ctrl_load_bit, rdata);
        apb_access(csr_pc_off, 1'b0, 32'd0, rdata, err);
        check_word("registers pc readback", frozen_pc, rdata);   // pc frozen here
        apb_access(32'h0000_0014, 1'b0, 32'd0, rdata, err);
        check_word("registers undefined pslverr", 32'd1, word_t'(err));
        finish_test("registers");

        load_words("program load", 32'd0, 16);  // still in load mode
        restart_fetch("program load", 32'd0);
        check_fetch_run("program load", 32'd0, 16);
        finish_test("program load");

        apb_write("data region", csr_ctrl_off, 32'd1 << ctrl_load_bit);
        load_words("data region", word_t'(depth), 8);     // region bit set
        for (int i = 0; i < 8; i++) begin
            dmem_addr = mem_depth_bits'(i);
            next_cycle();
            check_word("data region dmem_rdata", dmem_model[i], dmem_rdata);
        end
        restart_fetch("data region", 32'd0);
        check_fetch_run("data region", 32'd0, 8);         // program still intact
        finish_test("data region");

        base_pc       = pc;
        offset        = $random(seed) % 16;   // signed, both directions
        branch        = 1'b1;
        branch_offset = offset;
        next_cycle();
        branch        = 1'b0;
        check_word("control flow branch", base_pc + 4 + offset * 4, pc);
        target        = $random(seed) & 32'h0000_003c;   // inside the program
        jump          = 1'b1;
        jump_target   = target;
        next_cycle();
        jump          = 1'b0;
        check_word("control flow jump", target, pc);
        base_pc       = pc;
        branch        = 1'b1;
        jump          = 1'b1;
        next_cycle();
        branch        = 1'b0;
        jump          = 1'b0;
        check_word("control flow branch and jump", base_pc + 4, pc);
        finish_test("control flow");

        hold    = 1'b1;
        base_pc = pc;
        next_cycle();                           // read port settles on held pc
        check_word("hold pc", base_pc, pc);
        check_word("hold instruction", imem_model[fetch_index(base_pc)], instruction);
        held_instr = instruction;
        repeat (4) begin
            next_cycle();
            check_word("hold pc", base_pc, pc);
            check_word("hold instruction steady", held_instr, instruction);
        end
        hold  = 1'b0;
        no_op = 1'b1;
        next_cycle();
        no_op = 1'b0;
        check_word("bubble if_no_op set", 32'd1, word_t'(if_no_op));
        next_cycle();
        check_word("bubble if_no_op clear", 32'd0, word_t'(if_no_op));
        finish_test("hold and bubble");

        apb_write("restart", csr_start_off, 32'h0000_0020);
        apb_write("restart", csr_ctrl_off, 32'd1 << ctrl_load_bit);
        frozen_pc = pc;
        repeat (5) next_cycle();
        check_word("restart frozen pc", frozen_pc, pc);
        restart_fetch("restart", 32'h0000_0020);
        check_fetch_run("restart", 32'h0000_0020, 8);
        finish_test("restart");

        $display("tests passed %0d, tests failed %0d, assertion failures %0d",
                 tests_passed, tests_failed, fetch_top_i.chk_i.fail_count);
        if (tests_failed == 0 && fetch_top_i.chk_i.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* sim/fetch_chk.sv */
`timescale 1ns/1ns

module fetch_chk (
    input logic             clk,
    input logic             rst_n,
    input logic             hold,
    input logic             freeze,
    input logic             restart,
    input logic             branch,
    input logic             jump,
    input logic             no_op,
    input logic             if_no_op,
    input fetch_pkg::word_t pc,
    input logic             psel,
    input logic             penable,
    input logic             pwrite,
    input fetch_pkg::word_t paddr,
    input logic             pslverr
);
    import fetch_pkg::*;

    int   fail_count = 0;                   // summed into the final verdict
    logic defined_off;                      // one of the five registers
    logic pc_write;                         // write to the read-only pc

    assign defined_off = paddr inside {csr_ctrl_off, csr_start_off, csr_addr_off,
                                       csr_data_off, csr_pc_off};
    assign pc_write    = pwrite & (paddr == csr_pc_off);

    // free running fetch, plain sequential step
    pc_step_a: assert property (@(posedge clk) disable iff (!rst_n)
        (!hold && !freeze && !restart && !branch && !jump) |=> (pc == $past(pc) + 32'd4))
        else begin
            $error("pc did not step by 4 with no control input active");
            fail_count++;
        end

    pc_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        hold |=> (pc == $past(pc)))
        else begin
            $error("pc moved while hold was high");
            fail_count++;
        end

    // bubble delayed by exactly one cycle
    bubble_a: assert property (@(posedge clk) disable iff (!rst_n)
        1'b1 |=> (if_no_op == $past(no_op)))
        else begin
            $error("if_no_op does not follow no_op of the previous cycle");
            fail_count++;
        end

    slverr_cause_a: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |-> (psel && penable && (!defined_off || pc_write)))
        else begin
            $error("pslverr raised on a defined register access");
            fail_count++;
        end

    slverr_undef_a: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && penable && !defined_off) |-> pslverr)
        else begin
            $error("pslverr missing on an undefined offset");
            fail_count++;
        end

endmodule

bind fetch_top fetch_chk chk_i (.*);

/* design/fetch_top.sv */
`timescale 1ns/1ns

module fetch_top #(
    parameter int mem_depth_bits = 8
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  fetch_pkg::word_t          paddr,
    input  fetch_pkg::word_t          pwdata,
    output fetch_pkg::word_t          prdata,
    output logic                      pready,
    output logic                      pslverr,
    input  logic                      hold,
    input  logic                      no_op,
    input  logic                      branch,
    input  fetch_pkg::word_t          branch_offset,
    input  logic                      jump,
    input  fetch_pkg::word_t          jump_target,
    input  logic [mem_depth_bits-1:0] dmem_addr,
    output fetch_pkg::word_t          pc,
    output fetch_pkg::word_t          instr_pc,
    output fetch_pkg::instr_t         instruction,
    output logic                      if_no_op,
    output fetch_pkg::word_t          dmem_rdata
);
    import fetch_pkg::*;

    logic  freeze;
    logic  restart;
    word_t start_pc;
    logic  istore_we;                       // region 0 writes
    logic  dstore_we;                       // region 1 writes

    mem_load_if #(.mem_depth_bits(mem_depth_bits)) load_bus ();

    assign istore_we = load_bus.we & ~load_bus.region;
    assign dstore_we = load_bus.we & load_bus.region;

    fetch_csr #(.mem_depth_bits(mem_depth_bits)) csr_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .cur_pc   (pc),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .freeze   (freeze),
        .restart  (restart),
        .start_pc (start_pc),
        .load     (load_bus.csr)
    );

    pc_unit pc_unit_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .hold          (hold),
        .no_op         (no_op),
        .freeze        (freeze),
        .restart       (restart),
        .start_pc      (start_pc),
        .branch        (branch),
        .branch_offset (branch_offset),
        .jump          (jump),
        .jump_target   (jump_target),
        .pc            (pc),
        .instr_pc      (instr_pc),
        .if_no_op      (if_no_op)
    );

    // word addressed, pc is in bytes
    sync_store #(.mem_depth_bits(mem_depth_bits), .payload_t(instr_t)) istore (
        .clk   (clk),
        .we    (istore_we),
        .waddr (load_bus.addr),
        .wdata (instr_t'(load_bus.wdata)),
        .raddr (pc[mem_depth_bits+1:2]),
        .rdata (instruction)
    );

    sync_store #(.mem_depth_bits(mem_depth_bits), .payload_t(word_t)) dstore (
        .clk   (clk),
        .we    (dstore_we),
        .waddr (load_bus.addr),
        .wdata (load_bus.wdata),
        .raddr (dmem_addr),
        .rdata (dmem_rdata)
    );

endmodule

/* design/sync_store.sv */
`timescale 1ns/1ns

module sync_store #(
    parameter int  mem_depth_bits = 8,
    parameter type payload_t      = fetch_pkg::word_t
) (
    input  logic                      clk,
    input  logic                      we,
    input  logic [mem_depth_bits-1:0] waddr,
    input  payload_t                  wdata,
    input  logic [mem_depth_bits-1:0] raddr,
    output payload_t                  rdata     // one cycle after raddr
);

    localparam int depth = 2 ** mem_depth_bits;

    payload_t mem [depth];

    // power-up contents cleared, fpga style init
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    // read before write on an address collision
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

/* design/pc_unit.sv */
`timescale 1ns/1ns

module pc_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             hold,          // hazard stall
    input  logic             no_op,         // bubble request
    input  logic             freeze,        // load mode
    input  logic             restart,       // load start_pc
    input  fetch_pkg::word_t start_pc,
    input  logic             branch,
    input  fetch_pkg::word_t branch_offset, // in words
    input  logic             jump,
    input  fetch_pkg::word_t jump_target,   // byte address
    output fetch_pkg::word_t pc,
    output fetch_pkg::word_t instr_pc,      // pc of the word on instruction
    output logic             if_no_op
);
    import fetch_pkg::*;

    word_t pc_seq;                          // pc + 4
    word_t pc_next;
    logic  pc_en;

    assign pc_seq = pc + 32'd4;
    assign pc_en  = ~(hold | freeze);

    // only a one-hot select counts, everything else steps
    always_comb begin
        case ({branch, jump, restart})
            3'b100:  pc_next = pc_seq + (branch_offset << 2);
            3'b010:  pc_next = jump_target;
            3'b001:  pc_next = start_pc;
            default: pc_next = pc_seq;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= '0;
            instr_pc <= '0;
            if_no_op <= 1'b0;
        end else begin
            if (pc_en) begin
                pc       <= pc_next;
                instr_pc <= pc;             // tracks the store's read latency
            end
            if_no_op <= no_op;              // bubble follows fetch by a cycle
        end
    end

endmodule

/* design/fetch_csr.sv */
`timescale 1ns/1ns

module fetch_csr #(
    parameter int mem_depth_bits = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  fetch_pkg::word_t paddr,
    input  fetch_pkg::word_t pwdata,
    input  fetch_pkg::word_t cur_pc,        // live pc for readback
    output fetch_pkg::word_t prdata,
    output logic             pready,
    output logic             pslverr,
    output logic             freeze,        // level, holds pc during load
    output logic             restart,       // pulse on leaving load mode
    output fetch_pkg::word_t start_pc,
    mem_load_if.csr          load
);
    import fetch_pkg::*;

    logic                    load_mode;     // ctrl[ctrl_load_bit]
    logic [mem_depth_bits:0] load_addr;     // msb selects region
    logic                    access;        // apb access phase
    logic                    wr_access;
    logic                    hit_ctrl;
    logic                    hit_start;
    logic                    hit_addr;
    logic                    hit_data;
    logic                    hit_pc;
    logic                    hit_any;

    assign access    = psel & penable;
    assign wr_access = access & pwrite;

    // full word compare, anything else is undefined
    assign hit_ctrl  = (paddr == csr_ctrl_off);
    assign hit_start = (paddr == csr_start_off);
    assign hit_addr  = (paddr == csr_addr_off);
    assign hit_data  = (paddr == csr_data_off);
    assign hit_pc    = (paddr == csr_pc_off);
    assign hit_any   = hit_ctrl | hit_start | hit_addr | hit_data | hit_pc;

    assign pready  = 1'b1;                  // zero wait states
    assign pslverr = access & (~hit_any | (pwrite & hit_pc));  // bad offset or ro write

    assign freeze = load_mode;

    // read mux
    always_comb begin
        prdata = '0;
        if (hit_ctrl) begin
            prdata[ctrl_load_bit] = load_mode;
        end else if (hit_start) begin
            prdata = start_pc;
        end else if (hit_addr) begin
            prdata = word_t'(load_addr);    // zero extended
        end else if (hit_data) begin
            prdata = load.wdata;            // last loaded word
        end else if (hit_pc) begin
            prdata = cur_pc;
        end
    end

    // control state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_mode <= 1'b0;
            restart   <= 1'b0;
            start_pc  <= '0;
            load_addr <= '0;
            load.we   <= 1'b0;
        end else begin
            // 1 -> 0 on the load bit, pc picks start_pc next edge
            restart <= wr_access & hit_ctrl & load_mode & ~pwdata[ctrl_load_bit];
            load.we <= wr_access & hit_data;     // store write one cycle later
            if (wr_access & hit_ctrl) begin
                load_mode <= pwdata[ctrl_load_bit];
            end
            if (wr_access & hit_start) begin
                start_pc <= pwdata;
            end
            if (wr_access & hit_addr) begin
                load_addr <= pwdata[mem_depth_bits:0];
            end else if (wr_access & hit_data) begin
                load_addr <= load_addr + 1'b1;   // auto increment, may roll into data region
            end
        end
    end

    // loader payload, captured with the strobe
    always_ff @(posedge clk) begin
        if (wr_access & hit_data) begin
            load.wdata  <= pwdata;
            load.addr   <= load_addr[mem_depth_bits-1:0];
            load.region <= load_addr[mem_depth_bits];
        end
    end

endmodule

/* design/mem_load_if.sv */
`timescale 1ns/1ns

interface mem_load_if #(
    parameter int mem_depth_bits = 8
) ();
    import fetch_pkg::*;

    logic                      we;              // single cycle write strobe
    logic                      region;          // 0 instr store, 1 data store
    logic [mem_depth_bits-1:0] addr;            // word address inside the store
    word_t                     wdata;           // payload

    // register block side
    modport csr (
        output we,
        output region,
        output addr,
        output wdata
    );

    // store side, top does the region split
    modport store (
        input  we,
        input  region,
        input  addr,
        input  wdata
    );

endinterface

/* design/fetch_pkg.sv */
package fetch_pkg;

    // basic datapath word
    typedef logic [31:0] word_t;

    // instruction layout, i-type view of the word
    typedef struct packed {
        logic [5:0]  opcode;                    // major opcode
        logic [4:0]  rs;                        // source register
        logic [4:0]  rt;                        // target register
        logic [15:0] imm;                       // immediate / low bits of r-type
    } instr_t;

    // apb register map, byte offsets
    localparam word_t csr_ctrl_off  = 32'h0000_0000;  // control
    localparam word_t csr_start_off = 32'h0000_0004;  // restart pc
    localparam word_t csr_addr_off  = 32'h0000_0008;  // loader word address
    localparam word_t csr_data_off  = 32'h0000_000C;  // loader data, write triggers store
    localparam word_t csr_pc_off    = 32'h0000_0010;  // current pc, read only

    // control register fields
    localparam int ctrl_load_bit = 0;           // load mode, fetch frozen while set

endpackage
